//--- design/ekf_slam_core.sv
`timescale 1ns/1ps

module ekf_slam_core #(
  parameter int RSA_DW  = slam_pkg::RSA_DW,
  parameter int ROW_LEN = slam_pkg::ROW_LEN
) (
  input  logic                          clk,
  input  logic                          sys_rst,
  input  logic                          i_stage_valid,
  input  slam_pkg::stage_cmd_t          i_stage_cmd,
  input  slam_pkg::slam_word_t          i_plb_dout,
  input  logic                          i_nl_done,
  input  slam_pkg::nl_result_u          i_nl_result,
  output logic                          o_stage_ready,
  output logic                          o_plb_en,
  output logic                          o_plb_we,
  output logic [slam_pkg::PLB_AW-1:0]   o_plb_addr,
  output slam_pkg::slam_word_t          o_plb_din,
  output logic                          o_nl_init,
  output slam_pkg::stage_code_t         o_nl_stage,
  output slam_pkg::nl_operand_t         o_nl_operand
);

  import slam_pkg::*;

  // latched command of the running stage
  stage_cmd_t  cmd_q;

  // phase handshakes between the blocks
  logic        read_start;
  logic        reads_done;
  logic        write_start;
  logic        writes_done;

  // estimates waiting for write-back
  est_bundle_t est;
  logic        est_ready;

  // nonlinear unit sees the stage code of the latched command
  assign o_nl_stage = cmd_q.stage;

  ekf_stage_ctrl u_ekf_stage_ctrl (
    .clk           (clk),
    .sys_rst       (sys_rst),
    .i_stage_valid (i_stage_valid),
    .i_stage_cmd   (i_stage_cmd),
    .i_reads_done  (reads_done),
    .i_nl_done     (i_nl_done),
    .i_est_ready   (est_ready),
    .i_writes_done (writes_done),
    .o_stage_ready (o_stage_ready),
    .o_cmd         (cmd_q),
    .o_read_start  (read_start),
    .o_nl_init     (o_nl_init),
    .o_write_start (write_start)
  );

  // operands go straight out to the nonlinear unit
  plb_access_seq #(
    .RSA_DW (RSA_DW)
  ) u_plb_access_seq (
    .clk           (clk),
    .sys_rst       (sys_rst),
    .i_read_start  (read_start),
    .i_cmd         (cmd_q),
    .i_write_start (write_start),
    .i_est         (est),
    .i_plb_dout    (i_plb_dout),
    .o_reads_done  (reads_done),
    .o_writes_done (writes_done),
    .o_operand     (o_nl_operand),
    .o_plb_en      (o_plb_en),
    .o_plb_we      (o_plb_we),
    .o_plb_addr    (o_plb_addr),
    .o_plb_din     (o_plb_din)
  );

  nl_result_capture #(
    .RSA_DW  (RSA_DW),
    .ROW_LEN (ROW_LEN)
  ) u_nl_result_capture (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_nl_done   (i_nl_done),
    .i_stage     (cmd_q.stage),
    .i_result    (i_nl_result),
    .i_operand   (o_nl_operand),
    .i_rk        (cmd_q.rk),
    .i_phi       (cmd_q.phi),
    .i_l_k       (cmd_q.l_k),
    .o_est       (est),
    .o_est_ready (est_ready)
  );

endmodule

//--- design/ekf_stage_ctrl.sv
`timescale 1ns/1ps

module ekf_stage_ctrl (
  input  logic                 clk,
  input  logic                 sys_rst,
  input  logic                 i_stage_valid,
  input  slam_pkg::stage_cmd_t i_stage_cmd,
  input  logic                 i_reads_done,
  input  logic                 i_nl_done,
  input  logic                 i_est_ready,
  input  logic                 i_writes_done,
  output logic                 o_stage_ready,
  output slam_pkg::stage_cmd_t o_cmd,
  output logic                 o_read_start,
  output logic                 o_nl_init,
  output logic                 o_write_start
);

  import slam_pkg::*;

  // stage sequencing states
  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_READ  = 3'd1;
  localparam logic [2:0] ST_WAIT  = 3'd2;
  localparam logic [2:0] ST_CAP   = 3'd3;
  localparam logic [2:0] ST_WRITE = 3'd4;

  logic [2:0] state;
  logic       accept;
  logic       legal;

  // valid/ready handshake with the PS
  assign accept = i_stage_valid & o_stage_ready;

  // only predict, new landmark and update run
  assign legal = i_stage_cmd.stage inside {STAGE_PRD, STAGE_NEW, STAGE_UPD};

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state         <= ST_IDLE;
      o_stage_ready <= 1'b1;
      o_read_start  <= 1'b0;
      o_nl_init     <= 1'b0;
      o_write_start <= 1'b0;
    end else begin
      // start and init are single-cycle pulses
      o_read_start  <= 1'b0;
      o_nl_init     <= 1'b0;
      o_write_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          // illegal code is taken off the bus and dropped
          if (accept && legal) begin
            state         <= ST_READ;
            o_stage_ready <= 1'b0;
            o_read_start  <= 1'b1;
          end
        end
        ST_READ: begin
          // operands complete, kick the nonlinear unit
          if (i_reads_done) begin
            state     <= ST_WAIT;
            o_nl_init <= 1'b1;
          end
        end
        ST_WAIT: begin
          // slow unit just parks us here
          if (i_nl_done) begin
            state <= ST_CAP;
          end
        end
        ST_CAP: begin
          // estimates registered one cycle after done
          if (i_est_ready) begin
            state         <= ST_WRITE;
            o_write_start <= 1'b1;
          end
        end
        ST_WRITE: begin
          if (i_writes_done) begin
            state         <= ST_IDLE;
            o_stage_ready <= 1'b1;
          end
        end
        default: begin
          state         <= ST_IDLE;
          o_stage_ready <= 1'b1;
        end
      endcase
    end
  end

  // latched command, held for the whole stage
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_cmd.stage <= STAGE_IDLE;
    end else if (accept && legal) begin
      o_cmd <= i_stage_cmd;
    end
  end

  // PS side must never offer the association code or garbage
  a_legal_stage: assert property (@(posedge clk) disable iff (sys_rst)
    i_stage_valid |-> legal);

  // one request outstanding, so done only answers our init
  a_done_in_wait: assert property (@(posedge clk) disable iff (sys_rst)
    i_nl_done |-> state == ST_WAIT);

endmodule

//--- design/nl_result_capture.sv
`timescale 1ns/1ps

module nl_result_capture #(
  parameter int RSA_DW  = slam_pkg::RSA_DW,
  parameter int ROW_LEN = slam_pkg::ROW_LEN
) (
  input  logic                  clk,
  input  logic                  sys_rst,
  input  logic                  i_nl_done,
  input  slam_pkg::stage_code_t i_stage,
  input  slam_pkg::nl_result_u  i_result,
  input  slam_pkg::nl_operand_t i_operand,
  input  slam_pkg::slam_word_t  i_rk,
  input  slam_pkg::slam_word_t  i_phi,
  input  logic [ROW_LEN-1:0]    i_l_k,
  output slam_pkg::est_bundle_t o_est,
  output logic                  o_est_ready
);

  import slam_pkg::*;

  // next estimate words wrap on overflow
  logic signed [RSA_DW-1:0] est_0;
  logic signed [RSA_DW-1:0] est_1;
  logic signed [RSA_DW-1:0] est_2;
  logic [PLB_AW-1:0]        est_base;
  logic [1:0]               est_cnt;

  // pick the union view that matches the stage
  always_comb begin
    case (i_stage)
      STAGE_PRD: begin
        // pose plus motion increments
        est_0    = i_operand.x + i_result.prd.d_x;
        est_1    = i_operand.y + i_result.prd.d_y;
        est_2    = i_operand.theta + i_result.prd.d_theta;
        est_base = POSE_BASE;
        est_cnt  = 2'd3;
      end
      STAGE_NEW: begin
        // landmark placed at pose plus offset
        est_0    = i_operand.x + i_result.newlm.off_x;
        est_1    = i_operand.y + i_result.newlm.off_y;
        est_2    = '0;
        est_base = lm_addr(i_l_k);
        est_cnt  = 2'd2;
      end
      STAGE_UPD: begin
        // innovation is measured minus predicted
        est_0    = i_rk - i_result.upd.pred_range;
        est_1    = i_phi - i_result.upd.pred_bearing;
        est_2    = '0;
        est_base = INNOV_BASE;
        est_cnt  = 2'd2;
      end
      default: begin
        // other codes write the pose back unchanged
        est_0    = i_operand.x;
        est_1    = i_operand.y;
        est_2    = i_operand.theta;
        est_base = POSE_BASE;
        est_cnt  = 2'd3;
      end
    endcase
  end

  // estimate payload loaded on done only
  always_ff @(posedge clk) begin
    if (i_nl_done) begin
      o_est.words[0] <= est_0;
      o_est.words[1] <= est_1;
      o_est.words[2] <= est_2;
      o_est.base     <= est_base;
      o_est.cnt      <= est_cnt;
    end
  end

  // ready exactly one cycle after done
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_est_ready <= 1'b0;
    end else begin
      o_est_ready <= i_nl_done;
    end
  end

endmodule

//--- design/plb_access_seq.sv
`timescale 1ns/1ps

module plb_access_seq #(
  parameter int RSA_DW = slam_pkg::RSA_DW
) (
  input  logic                          clk,
  input  logic                          sys_rst,
  input  logic                          i_read_start,
  input  slam_pkg::stage_cmd_t          i_cmd,
  input  logic                          i_write_start,
  input  slam_pkg::est_bundle_t         i_est,
  input  slam_pkg::slam_word_t          i_plb_dout,
  output logic                          o_reads_done,
  output logic                          o_writes_done,
  output slam_pkg::nl_operand_t         o_operand,
  output logic                          o_plb_en,
  output logic                          o_plb_we,
  output logic [slam_pkg::PLB_AW-1:0]   o_plb_addr,
  output slam_pkg::slam_word_t          o_plb_din
);

  import slam_pkg::*;

  // read side
  logic [2:0]                            rd_cnt;
  logic [2:0]                            rd_idx;
  logic                                  rd_busy;
  logic                                  rd_issue;
  logic                                  rd_last;
  logic [PLB_AW-1:0]                     rd_addr;
  logic [PLB_RD_LATENCY-1:0]             rd_vld_sh;
  logic [PLB_RD_LATENCY-1:0]             rd_last_sh;
  logic [PLB_RD_LATENCY-1:0][2:0]        rd_tag_sh;

  // write side
  logic [1:0]                            wr_idx;
  logic                                  wr_busy;
  logic                                  wr_issue;
  logic                                  wr_last;
  logic signed [RSA_DW-1:0]              wr_word;

  // words fetched per stage
  always_comb begin
    case (i_cmd.stage)
      STAGE_NEW: rd_cnt = 3'd2;
      STAGE_UPD: rd_cnt = 3'd5;
      default:   rd_cnt = 3'd3;
    endcase
  end

  // read slot n also names operand field n
  // 0..2 pose, 3..4 landmark
  always_comb begin
    if (rd_idx >= 3'd3) begin
      rd_addr = lm_addr(i_cmd.l_k) + PLB_AW'(rd_idx - 3'd3);
    end else begin
      rd_addr = POSE_BASE + PLB_AW'(rd_idx);
    end
  end

  // first read goes out in the start cycle itself
  assign rd_issue = i_read_start | rd_busy;
  assign rd_last  = (rd_idx == rd_cnt - 3'd1);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      rd_busy <= 1'b0;
      rd_idx  <= '0;
    end else if (rd_issue) begin
      if (rd_last) begin
        rd_busy <= 1'b0;
        rd_idx  <= '0;
      end else begin
        rd_busy <= 1'b1;
        rd_idx  <= rd_idx + 3'd1;
      end
    end
  end

  // delayed valid follows each read through the RAM latency
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      rd_vld_sh <= '0;
    end else begin
      rd_vld_sh[0] <= rd_issue;
      for (int i = 1; i < PLB_RD_LATENCY; i++) begin
        rd_vld_sh[i] <= rd_vld_sh[i-1];
      end
    end
  end

  // tag and last ride alongside, qualified by valid
  always_ff @(posedge clk) begin
    rd_tag_sh[0]  <= rd_idx;
    rd_last_sh[0] <= rd_last;
    for (int i = 1; i < PLB_RD_LATENCY; i++) begin
      rd_tag_sh[i]  <= rd_tag_sh[i-1];
      rd_last_sh[i] <= rd_last_sh[i-1];
    end
  end

  // steer returning word into its operand field
  always_ff @(posedge clk) begin
    if (rd_vld_sh[PLB_RD_LATENCY-1]) begin
      case (rd_tag_sh[PLB_RD_LATENCY-1])
        3'd0:    o_operand.x     <= i_plb_dout;
        3'd1:    o_operand.y     <= i_plb_dout;
        3'd2:    o_operand.theta <= i_plb_dout;
        3'd3:    o_operand.lx    <= i_plb_dout;
        default: o_operand.ly    <= i_plb_dout;
      endcase
    end
  end

  // last data word on dout this cycle
  assign o_reads_done = rd_vld_sh[PLB_RD_LATENCY-1] & rd_last_sh[PLB_RD_LATENCY-1];

  // writes stream from the bundle base, one per cycle
  assign wr_issue = i_write_start | wr_busy;
  assign wr_last  = (wr_idx == i_est.cnt - 2'd1);
  assign wr_word  = i_est.words[wr_idx];

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_busy <= 1'b0;
      wr_idx  <= '0;
    end else if (wr_issue) begin
      if (wr_last) begin
        wr_busy <= 1'b0;
        wr_idx  <= '0;
      end else begin
        wr_busy <= 1'b1;
        wr_idx  <= wr_idx + 2'd1;
      end
    end
  end

  assign o_writes_done = wr_issue & wr_last;

  // single port, writes take priority on the address mux
  assign o_plb_en   = rd_issue | wr_issue;
  assign o_plb_we   = wr_issue;
  assign o_plb_addr = wr_issue ? i_est.base + PLB_AW'(wr_idx) : rd_addr;
  assign o_plb_din  = wr_word;

  // write-back only after every read word has landed
  a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (sys_rst)
    (i_read_start | rd_busy | (|rd_vld_sh)) |-> !wr_issue);

endmodule

//--- design/slam_pkg.sv
package slam_pkg;

  // datapath word width, also the top-level default
  localparam int RSA_DW = 32;

  // landmark index width
  localparam int ROW_LEN = 10;

  // PLB word address width
  localparam int PLB_AW = 32;

  // read enable to valid dout
  localparam int PLB_RD_LATENCY = 1;

  typedef logic signed [RSA_DW-1:0] slam_word_t;

  // 3'd4 was data association, not supported here
  typedef enum logic [2:0] {
    STAGE_IDLE = 3'd0,
    STAGE_PRD  = 3'd1,
    STAGE_NEW  = 3'd2,
    STAGE_UPD  = 3'd3
  } stage_code_t;

  // PS block RAM word map
  // pose x, y, theta at 0..2
  localparam logic [PLB_AW-1:0] POSE_BASE  = 32'd0;
  // landmark k: x at LM_BASE + 2k, y right after
  localparam logic [PLB_AW-1:0] LM_BASE    = 32'd3;
  // two innovation words
  localparam logic [PLB_AW-1:0] INNOV_BASE = 32'd1020;

  // word address of landmark x for index l_k
  function automatic logic [PLB_AW-1:0] lm_addr(input logic [ROW_LEN-1:0] l_k);
    return LM_BASE + (PLB_AW'(l_k) << 1);
  endfunction

  // stage command from the PS
  typedef struct packed {
    stage_code_t            stage;
    logic [ROW_LEN-1:0]     l_k;
    slam_word_t             rk;
    slam_word_t             phi;
  } stage_cmd_t;

  // operands handed to the nonlinear unit
  typedef struct packed {
    slam_word_t x;
    slam_word_t y;
    slam_word_t theta;
    slam_word_t lx;
    slam_word_t ly;
  } nl_operand_t;

  // plain view, result_0 in the top word
  typedef struct packed {
    slam_word_t result_0;
    slam_word_t result_1;
    slam_word_t result_2;
    slam_word_t result_3;
    slam_word_t result_4;
    slam_word_t result_5;
  } nl_raw_t;

  // predict: motion increments
  typedef struct packed {
    slam_word_t rsv_0;
    slam_word_t d_theta;
    slam_word_t d_x;
    slam_word_t d_y;
    slam_word_t rsv_4;
    slam_word_t rsv_5;
  } nl_prd_view_t;

  // new landmark: offset from the pose, y word comes first
  typedef struct packed {
    slam_word_t rsv_0;
    slam_word_t rsv_1;
    slam_word_t off_y;
    slam_word_t off_x;
    slam_word_t rsv_4;
    slam_word_t rsv_5;
  } nl_new_view_t;

  // update: predicted measurement
  typedef struct packed {
    slam_word_t pred_range;
    slam_word_t pred_bearing;
    slam_word_t rsv_2;
    slam_word_t rsv_3;
    slam_word_t rsv_4;
    slam_word_t rsv_5;
  } nl_upd_view_t;

  // one result word set, decoded per stage
  typedef union packed {
    nl_raw_t      raw;
    nl_prd_view_t prd;
    nl_new_view_t newlm;
    nl_upd_view_t upd;
  } nl_result_u;

  // estimate words to write back, words[0] goes to base
  typedef struct packed {
    slam_word_t [2:0]     words;
    logic [PLB_AW-1:0]    base;
    logic [1:0]           cnt;
  } est_bundle_t;

endpackage

//--- flist.f
design/slam_pkg.sv
design/ekf_stage_ctrl.sv
design/plb_access_seq.sv
design/nl_result_capture.sv
design/ekf_slam_core.sv
sim/tb_ekf_slam_core.sv

//--- sim/tb_ekf_slam_core.sv
`timescale 1ns/1ps

module tb_ekf_slam_core;

  import slam_pkg::*;

  localparam int N_CMD     = 60;
  localparam int N_LM      = 16;
  localparam int TIMEOUT   = 200;
  localparam int MEM_WORDS = 1024;
  localparam int SEED      = 32'h3e906840;

  logic                clk;
  logic                sys_rst;
  logic                i_stage_valid;
  stage_cmd_t          i_stage_cmd;
  slam_word_t          i_plb_dout;
  logic                i_nl_done;
  nl_result_u          i_nl_result;
  logic                o_stage_ready;
  logic                o_plb_en;
  logic                o_plb_we;
  logic [PLB_AW-1:0]   o_plb_addr;
  slam_word_t          o_plb_din;
  logic                o_nl_init;
  stage_code_t         o_nl_stage;
  nl_operand_t         o_nl_operand;

  // pregenerated stimulus, indexed by command number
  stage_cmd_t  cmds [N_CMD];
  bit          hold_next [N_CMD];
  int unsigned nl_delay [N_CMD];
  slam_word_t  nl_res [N_CMD][6];

  // block RAM contents and the reference copy
  slam_word_t  mem [MEM_WORDS];
  slam_word_t  exp_mem [MEM_WORDS];

  int          errors;
  int          checks;
  int          init_cnt;
  int          acc_cnt;
  bit          timed_out;

  // nonlinear unit model state
  bit          nl_busy;
  int unsigned nl_wait;
  nl_result_u  nl_res_q;

  ekf_slam_core #(
    .RSA_DW  (RSA_DW),
    .ROW_LEN (ROW_LEN)
  ) uut (
    .clk           (clk),
    .sys_rst       (sys_rst),
    .i_stage_valid (i_stage_valid),
    .i_stage_cmd   (i_stage_cmd),
    .i_plb_dout    (i_plb_dout),
    .i_nl_done     (i_nl_done),
    .i_nl_result   (i_nl_result),
    .o_stage_ready (o_stage_ready),
    .o_plb_en      (o_plb_en),
    .o_plb_we      (o_plb_we),
    .o_plb_addr    (o_plb_addr),
    .o_plb_din     (o_plb_din),
    .o_nl_init     (o_nl_init),
    .o_nl_stage    (o_nl_stage),
    .o_nl_operand  (o_nl_operand)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // background pattern, every address bit matters
  function automatic slam_word_t fill_word(input int a);
    return slam_word_t'(a * 32'h9e3779b1) ^ 32'h5a3c96e1;
  endfunction

  function automatic string stage_name(input stage_code_t s);
    case (s)
      STAGE_PRD: return "predict";
      STAGE_NEW: return "new_landmark";
      STAGE_UPD: return "update";
      default:   return "idle";
    endcase
  endfunction

  task automatic check_word(input string name, input slam_word_t expv, input slam_word_t actv);
    checks++;
    assert (actv === expv) else begin
      errors++;
      $display("error %s: expected %h actual %h", name, expv, actv);
    end
  endtask

  // block RAM, one cycle read latency
  always @(posedge clk) begin
    if (!sys_rst && o_plb_en) begin
      if (o_plb_we) begin
        assert (o_plb_addr < MEM_WORDS) else begin
          errors++;
          $display("write to address %0d outside the block RAM", o_plb_addr);
        end
        if (o_plb_addr < MEM_WORDS) begin
          mem[o_plb_addr] <= o_plb_din;
        end
      end else if (o_plb_addr < MEM_WORDS) begin
        i_plb_dout <= mem[o_plb_addr];
      end else begin
        i_plb_dout <= fill_word(int'(o_plb_addr));
      end
    end
  end

  // every handshake on the command port
  always @(posedge clk) begin
    if (!sys_rst && i_stage_valid && o_stage_ready) begin
      acc_cnt++;
    end
  end

  // operands must mirror the reference memory for the words each stage reads
  task automatic check_operand(input int idx);
    int    a;
    string tag;
    tag = $sformatf("init %0d %s", idx, stage_name(cmds[idx].stage));
    a = int'(LM_BASE) + 2 * int'(cmds[idx].l_k);
    checks++;
    assert (o_nl_stage == cmds[idx].stage) else begin
      errors++;
      $display("error %s stage: expected %0d actual %0d", tag, cmds[idx].stage, o_nl_stage);
    end
    check_word({tag, " x"}, exp_mem[0], o_nl_operand.x);
    check_word({tag, " y"}, exp_mem[1], o_nl_operand.y);
    if (cmds[idx].stage != STAGE_NEW) begin
      check_word({tag, " theta"}, exp_mem[2], o_nl_operand.theta);
    end
    if (cmds[idx].stage == STAGE_UPD) begin
      check_word({tag, " lx"}, exp_mem[a], o_nl_operand.lx);
      check_word({tag, " ly"}, exp_mem[a + 1], o_nl_operand.ly);
    end
  endtask

  // nonlinear unit, answers after the pregenerated delay
  always @(posedge clk) begin
    if (sys_rst) begin
      i_nl_done <= 1'b0;
      nl_busy = 1'b0;
    end else begin
      i_nl_done <= 1'b0;
      if (nl_busy) begin
        // core must hold off the PS while we are slow
        assert (!o_stage_ready) else begin
          errors++;
          $display("stage ready went high while the nonlinear unit was busy");
        end
        if (nl_wait == 0) begin
          i_nl_done   <= 1'b1;
          i_nl_result <= nl_res_q;
          nl_busy = 1'b0;
        end else begin
          nl_wait = nl_wait - 1;
        end
      end
      if (o_nl_init) begin
        assert (!nl_busy && init_cnt < N_CMD) else begin
          errors++;
          $display("init pulse %0d arrived with no command left for it", init_cnt);
        end
        if (init_cnt < N_CMD) begin
          check_operand(init_cnt);
          nl_wait = nl_delay[init_cnt];
          nl_res_q.raw.result_0 = nl_res[init_cnt][0];
          nl_res_q.raw.result_1 = nl_res[init_cnt][1];
          nl_res_q.raw.result_2 = nl_res[init_cnt][2];
          nl_res_q.raw.result_3 = nl_res[init_cnt][3];
          nl_res_q.raw.result_4 = nl_res[init_cnt][4];
          nl_res_q.raw.result_5 = nl_res[init_cnt][5];
          nl_busy = 1'b1;
        end
        init_cnt++;
      end
    end
  end

  // reference update for stage k, straight from the stage rules
  task automatic apply_model(input int k);
    int a;
    a = int'(LM_BASE) + 2 * int'(cmds[k].l_k);
    case (cmds[k].stage)
      STAGE_PRD: begin
        exp_mem[0] = exp_mem[0] + nl_res[k][2];
        exp_mem[1] = exp_mem[1] + nl_res[k][3];
        exp_mem[2] = exp_mem[2] + nl_res[k][1];
      end
      STAGE_NEW: begin
        exp_mem[a]     = exp_mem[0] + nl_res[k][3];
        exp_mem[a + 1] = exp_mem[1] + nl_res[k][2];
      end
      STAGE_UPD: begin
        exp_mem[INNOV_BASE]     = cmds[k].rk - nl_res[k][0];
        exp_mem[INNOV_BASE + 1] = cmds[k].phi - nl_res[k][1];
      end
      default: begin
      end
    endcase
  endtask

  // whole RAM, so untouched words are covered too
  task automatic compare_mem(input int k);
    for (int a = 0; a < MEM_WORDS; a++) begin
      check_word($sformatf("stage %0d %s word %0d", k, stage_name(cmds[k].stage), a),
                 exp_mem[a], mem[a]);
    end
  endtask

  // check_now: handshake sampled at the current edge, no extra cycle
  task automatic wait_accept(input int k, input bit check_now);
    int n;
    n = 0;
    if (!check_now) begin
      @(posedge clk);
    end
    while (!(i_stage_valid && o_stage_ready) && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    assert (i_stage_valid && o_stage_ready) else begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: command %0d was never accepted", k);
    end
  endtask

  task automatic wait_ready_back(input int k);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!o_stage_ready && n < TIMEOUT);
    assert (o_stage_ready) else begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: stage %0d never returned stage ready", k);
    end
  endtask

  initial begin : main_seq
    int k;
    bit held;
    sys_rst       = 1'b1;
    i_stage_valid = 1'b0;
    i_stage_cmd   = '0;
    i_plb_dout    = '0;
    i_nl_done     = 1'b0;
    i_nl_result   = '0;
    errors        = 0;
    checks        = 0;
    init_cnt      = 0;
    acc_cnt       = 0;
    timed_out     = 1'b0;
    void'($urandom(SEED));
    for (k = 0; k < N_CMD; k++) begin
      cmds[k].stage = stage_code_t'(1 + ($urandom % 3));
      cmds[k].l_k   = ROW_LEN'($urandom % N_LM);
      cmds[k].rk    = $urandom;
      cmds[k].phi   = $urandom;
      hold_next[k]  = $urandom % 2;
      nl_delay[k]   = $urandom % 8;
      for (int j = 0; j < 6; j++) begin
        nl_res[k][j] = $urandom;
      end
    end
    // random pose, landmarks and innovation, pattern elsewhere
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = fill_word(a);
    end
    for (int a = 0; a < int'(LM_BASE) + 2 * N_LM; a++) begin
      mem[a] = $urandom;
    end
    mem[INNOV_BASE]     = $urandom;
    mem[INNOV_BASE + 1] = $urandom;
    exp_mem = mem;

    repeat (5) @(posedge clk);
    sys_rst <= 1'b0;
    @(posedge clk);
    checks++;
    assert (o_stage_ready === 1'b1 && o_nl_init === 1'b0 && o_plb_en === 1'b0 &&
            o_plb_we === 1'b0) else begin
      errors++;
      $display("error reset: expected ready=1 init=0 en=0 we=0 actual ready=%b init=%b en=%b we=%b",
               o_stage_ready, o_nl_init, o_plb_en, o_plb_we);
    end

    held = 1'b0;
    for (k = 0; k < N_CMD; k++) begin
      if (!held) begin
        i_stage_valid <= 1'b1;
        i_stage_cmd   <= cmds[k];
      end
      wait_accept(k, held);
      if (timed_out) begin
        break;
      end
      // some commands sit valid through the whole busy period
      held = (k + 1 < N_CMD) && hold_next[k + 1];
      if (held) begin
        i_stage_cmd <= cmds[k + 1];
      end else begin
        i_stage_valid <= 1'b0;
      end
      wait_ready_back(k);
      if (timed_out) begin
        break;
      end
      apply_model(k);
      compare_mem(k);
    end

    if (!timed_out) begin
      checks++;
      assert (acc_cnt == N_CMD && init_cnt == acc_cnt) else begin
        errors++;
        $display("error handshake count: expected %0d accepted and %0d init actual %0d and %0d",
                 N_CMD, N_CMD, acc_cnt, init_cnt);
      end
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
